// ==== enable_gen.f ====
source/enable_gen_pkg.sv
source/enable_gen_regs.sv
source/enable_gen_ctrl.sv
source/period_counter.sv
source/enable_pulse_unit.sv
source/enable_gen.sv
tb/enable_gen_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the enable_gen testbench with Verilator.
# The exit status is 0 only if the log holds the pass line.

set -u

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing -Wno-fatal \
    --top-module enable_gen_tb \
    -f enable_gen.f \
    -o enable_gen_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/enable_gen_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// ==== source/enable_gen.sv ====
/*
 * Programmable enable-pulse generator with a Wishbone classic register
 * interface, a period counter and an external timebase pass-through
 */
`timescale 1ns/1ps
`default_nettype none

module enable_gen #(
    parameter int counter_width = 16,
    parameter enable_gen_pkg::bus_word_t base_address = '0
) (
    input  logic clock,
    input  logic rst_n,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  enable_gen_pkg::bus_word_t wb_adr,
    input  enable_gen_pkg::bus_word_t wb_dat_w,
    output enable_gen_pkg::bus_word_t wb_dat_r,
    output logic wb_ack,
    input  logic gen_enable_in,
    input  logic ext_timebase,
    output logic enable_out
);

    logic run;
    logic [counter_width-1:0] period;
    logic [counter_width-1:0] threshold;
    logic [counter_width-1:0] count;
    logic count_step;
    logic count_clear;
    logic pass_select;

    enable_gen_regs #(
        .counter_width(counter_width),
        .base_address(base_address)
    ) i_regs (
        .clock(clock),
        .rst_n(rst_n),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .run(run),
        .period(period),
        .threshold(threshold)
    );

    enable_gen_ctrl #(
        .counter_width(counter_width)
    ) i_ctrl (
        .clock(clock),
        .rst_n(rst_n),
        .run(run),
        .gen_enable_in(gen_enable_in),
        .period(period),
        .count_step(count_step),
        .count_clear(count_clear),
        .pass_select(pass_select)
    );

    period_counter #(
        .counter_width(counter_width)
    ) i_counter (
        .clock(clock),
        .rst_n(rst_n),
        .count_step(count_step),
        .count_clear(count_clear),
        .period(period),
        .count(count)
    );

    enable_pulse_unit #(
        .counter_width(counter_width)
    ) i_pulse (
        .clock(clock),
        .rst_n(rst_n),
        .count(count),
        .threshold(threshold),
        .count_step(count_step),
        .pass_select(pass_select),
        .ext_timebase(ext_timebase),
        .enable_out(enable_out)
    );

endmodule

`default_nettype wire

// ==== source/enable_gen_ctrl.sv ====
/*
 * Enable-pulse generator controller: picks idle, counting or
 * external timebase pass-through from the enables and the period
 */
`timescale 1ns/1ps
`default_nettype none

module enable_gen_ctrl #(
    parameter int counter_width = 16
) (
    input  logic clock,
    input  logic rst_n,
    input  logic run,
    input  logic gen_enable_in,
    input  logic [counter_width-1:0] period,
    output logic count_step,
    output logic count_clear,
    output logic pass_select
);

    import enable_gen_pkg::*;

    // Shortest period the counter can turn into a timebase
    localparam logic [counter_width-1:0] min_period = 2;

    gen_state_t state;
    gen_state_t next_state;
    logic enabled;

    assign enabled = run || gen_enable_in;

    // The target state depends only on the inputs, so any change is
    // followed within one clock
    always_comb begin
        if (!enabled) begin
            next_state = st_idle;
        end else if (period >= min_period) begin
            next_state = st_count;
        end else begin
            next_state = st_pass;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // The counter is held at zero whenever it is not stepping, so each
    // counting run starts from a known phase
    always_comb begin
        count_step = 1'b0;
        count_clear = 1'b1;
        pass_select = 1'b0;
        case (state)
            st_count: begin
                count_step = 1'b1;
                count_clear = 1'b0;
            end
            st_pass: pass_select = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/enable_gen_pkg.sv ====
/*
 * Enable-pulse generator shared definitions: bus word, register map
 * and the decoded views of the control word and controller state
 */
`default_nettype none

package enable_gen_pkg;

    typedef logic [31:0] bus_word_t;

    typedef logic [1:0] reg_index_t;

    // Register map, word index taken from address bits 3 to 2
    localparam reg_index_t reg_ctrl = 2'd0;
    localparam reg_index_t reg_period = 2'd1;
    localparam reg_index_t reg_threshold = 2'd2;

    // Only the run bit of the control word is implemented
    localparam bus_word_t ctrl_write_mask = 32'h0000_0001;

    typedef struct packed {
        logic [30:0] reserved;
        logic run;
    } ctrl_fields_t;

    typedef union packed {
        bus_word_t raw;
        ctrl_fields_t fields;
    } ctrl_word_t;

    typedef enum logic [1:0] {st_idle, st_count, st_pass} gen_state_t;

endpackage

`default_nettype wire

// ==== source/enable_gen_regs.sv ====
/*
 * Wishbone classic register block of the enable-pulse generator.
 * Holds the control, period and threshold words with zero-extended readback
 */
`timescale 1ns/1ps
`default_nettype none

module enable_gen_regs #(
    parameter int counter_width = 16,
    parameter enable_gen_pkg::bus_word_t base_address = '0
) (
    input  logic clock,
    input  logic rst_n,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  enable_gen_pkg::bus_word_t wb_adr,
    input  enable_gen_pkg::bus_word_t wb_dat_w,
    output enable_gen_pkg::bus_word_t wb_dat_r,
    output logic wb_ack,
    output logic run,
    output logic [counter_width-1:0] period,
    output logic [counter_width-1:0] threshold
);

    import enable_gen_pkg::*;

    ctrl_word_t ctrl_q;
    logic [counter_width-1:0] period_q;
    logic [counter_width-1:0] threshold_q;

    logic request;
    logic addr_hit;
    reg_index_t index;
    bus_word_t read_data;

    // The cycle right after an ack never starts a new access, so one
    // request is acknowledged exactly once
    assign request = wb_cyc && wb_stb && !wb_ack;

    // Upper address bits select the block, bits 3 to 2 pick the word
    assign addr_hit = (wb_adr[31:4] == base_address[31:4]);
    assign index = wb_adr[3:2];

    always_comb begin
        read_data = '0;
        if (addr_hit) begin
            case (index)
                reg_ctrl: read_data = ctrl_q.raw;
                reg_period: read_data[counter_width-1:0] = period_q;
                reg_threshold: read_data[counter_width-1:0] = threshold_q;
                default: read_data = '0;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            ctrl_q.raw <= '0;
            period_q <= '0;
            threshold_q <= '0;
        end else begin
            wb_ack <= request;
            if (request && wb_we && addr_hit) begin
                case (index)
                    // Reserved control bits are dropped here so they read back as zero
                    reg_ctrl: ctrl_q.raw <= wb_dat_w & ctrl_write_mask;
                    reg_period: period_q <= wb_dat_w[counter_width-1:0];
                    reg_threshold: threshold_q <= wb_dat_w[counter_width-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Read data is captured with the request and is valid while wb_ack is high
    always_ff @(posedge clock) begin
        if (request && !wb_we) begin
            wb_dat_r <= read_data;
        end
    end

    assign run = ctrl_q.fields.run;
    assign period = period_q;
    assign threshold = threshold_q;

endmodule

`default_nettype wire

// ==== source/enable_pulse_unit.sv ====
/*
 * Enable pulse output stage: registered threshold match while counting,
 * or the external timebase delayed by one clock in pass-through
 */
`timescale 1ns/1ps
`default_nettype none

module enable_pulse_unit #(
    parameter int counter_width = 16
) (
    input  logic clock,
    input  logic rst_n,
    input  logic [counter_width-1:0] count,
    input  logic [counter_width-1:0] threshold,
    input  logic count_step,
    input  logic pass_select,
    input  logic ext_timebase,
    output logic enable_out
);

    logic match;
    logic pulse_next;

    // The count sits on each value for one clock, so a match is one cycle long
    assign match = count_step && (count == threshold);

    assign pulse_next = pass_select ? ext_timebase : match;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            enable_out <= 1'b0;
        end else begin
            enable_out <= pulse_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/period_counter.sv ====
/*
 * Period counter, steps from 0 to period-1 and wraps back to 0
 */
`timescale 1ns/1ps
`default_nettype none

module period_counter #(
    parameter int counter_width = 16
) (
    input  logic clock,
    input  logic rst_n,
    input  logic count_step,
    input  logic count_clear,
    input  logic [counter_width-1:0] period,
    output logic [counter_width-1:0] count
);

    logic [counter_width-1:0] last_count;
    logic at_end;

    assign last_count = period - 1'b1;

    // Compare with >= rather than == so that a period lowered below the
    // running count wraps on the next step
    assign at_end = (count >= last_count);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            count <= '0;
        end else if (count_clear) begin
            count <= '0;
        end else if (count_step) begin
            if (at_end) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/enable_gen_tb.sv ====
/*
 * Testbench for the enable-pulse generator. Checks the Wishbone registers,
 * then applies a table of pulse, pass-through and idle tests in a loop
 */
`timescale 1ns/1ps
`default_nettype none

module enable_gen_tb;

    import enable_gen_pkg::*;

    localparam int counter_width = 16;
    localparam bus_word_t base_address = 32'h0000_0000;
    localparam bus_word_t width_mask = bus_word_t'((64'd1 << counter_width) - 64'd1);
    localparam int window_cycles = 64;
    localparam int pass_cycles = 32;
    localparam int ack_timeout = 16;
    localparam int num_rows = 9;

    typedef enum logic [1:0] {mode_idle, mode_count, mode_pass} test_mode_t;

    typedef struct packed {
        logic [15:0] period;
        logic [15:0] threshold;
        logic run;
        logic gen_en;
        test_mode_t mode;
        logic [7:0] pulses;
        logic [15:0] spacing;
    } test_row_t;

    logic clock;
    logic rst_n;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    bus_word_t wb_adr;
    bus_word_t wb_dat_w;
    bus_word_t wb_dat_r;
    logic wb_ack;
    logic gen_enable_in;
    logic ext_timebase;
    logic enable_out;
    integer seed;

    // Periods in counting rows divide the window, so the pulse count does not depend on phase
    string row_names [num_rows] = '{
        "count_run_p8_t3", "count_run_p4_t0", "count_pin_p8_t3", "count_pin_p16_t15",
        "count_both_p2_t1", "count_thr_at_period", "pass_run_p0", "pass_pin_p1",
        "idle_both_low"
    };

    test_row_t rows [num_rows] = '{
        '{16'd8, 16'd3, 1'b1, 1'b0, mode_count, 8'd8, 16'd8},
        '{16'd4, 16'd0, 1'b1, 1'b0, mode_count, 8'd16, 16'd4},
        '{16'd8, 16'd3, 1'b0, 1'b1, mode_count, 8'd8, 16'd8},
        '{16'd16, 16'd15, 1'b0, 1'b1, mode_count, 8'd4, 16'd16},
        '{16'd2, 16'd1, 1'b1, 1'b1, mode_count, 8'd32, 16'd2},
        '{16'd8, 16'd8, 1'b1, 1'b0, mode_count, 8'd0, 16'd0},
        '{16'd0, 16'd0, 1'b1, 1'b0, mode_pass, 8'd0, 16'd0},
        '{16'd1, 16'd0, 1'b0, 1'b1, mode_pass, 8'd0, 16'd0},
        '{16'd8, 16'd3, 1'b0, 1'b0, mode_idle, 8'd0, 16'd0}
    };

    enable_gen #(
        .counter_width(counter_width),
        .base_address(base_address)
    ) i_dut (
        .clock(clock),
        .rst_n(rst_n),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .gen_enable_in(gen_enable_in),
        .ext_timebase(ext_timebase),
        .enable_out(enable_out)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_word(input string name, input bus_word_t expected,
                              input bus_word_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s expected %b actual %b", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        stop_on_failure();
    endtask

    function automatic bus_word_t reg_addr(input reg_index_t index);
        return base_address + {28'd0, index, 2'b00};
    endfunction

    task automatic drive_random_timebase();
        integer r;
        r = $random(seed);
        ext_timebase = r[0];
    endtask

    // Bus tasks start and end just after a falling edge
    task automatic wb_write(input bus_word_t addr, input bus_word_t data);
        int cycles;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b1;
        wb_adr = addr;
        wb_dat_w = data;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles = cycles + 1;
            if (cycles > ack_timeout) report_timeout("wb_ack on a register write");
        end while (!wb_ack);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_read(input bus_word_t addr, output bus_word_t data);
        int cycles;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b0;
        wb_adr = addr;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles = cycles + 1;
            if (cycles > ack_timeout) report_timeout("wb_ack on a register read");
        end while (!wb_ack);
        data = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic register_readback();
        bus_word_t data;
        bus_word_t value;
        bus_word_t period_value;
        int idx;
        for (idx = 0; idx < 4; idx = idx + 1) begin
            wb_read(reg_addr(reg_index_t'(idx)), data);
            check_word("reset readback", 32'h0, data);
        end
        value = $random(seed);
        wb_write(reg_addr(reg_ctrl), value | 32'h8000_0001);
        wb_read(reg_addr(reg_ctrl), data);
        check_word("ctrl readback", 32'h0000_0001, data);
        period_value = $random(seed);
        period_value = period_value | 32'h0001_0000;
        wb_write(reg_addr(reg_period), period_value);
        wb_read(reg_addr(reg_period), data);
        check_word("period readback", period_value & width_mask, data);
        value = $random(seed);
        value = value | 32'h8000_0000;
        wb_write(reg_addr(reg_threshold), value);
        wb_read(reg_addr(reg_threshold), data);
        check_word("threshold readback", value & width_mask, data);
        value = $random(seed);
        wb_write(reg_addr(2'd3), value);
        wb_read(reg_addr(2'd3), data);
        check_word("unused index readback", 32'h0, data);
        // Accesses outside the block are acknowledged but change nothing.
        // The outside address carries the period index in bits 3 to 2
        wb_write(base_address + 32'h14, ~period_value);
        wb_read(base_address + 32'h14, data);
        check_word("outside block readback", 32'h0, data);
        wb_read(reg_addr(reg_period), data);
        check_word("period after outside write", period_value & width_mask, data);
        wb_write(reg_addr(reg_ctrl), 32'h0);
        wb_write(reg_addr(reg_period), 32'h0);
        wb_write(reg_addr(reg_threshold), 32'h0);
    endtask

    task automatic wait_rise(input string name, input int timeout);
        int cycles;
        logic prev;
        logic rose;
        prev = enable_out;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles = cycles + 1;
            if (cycles > timeout) report_timeout({"the first pulse of ", name});
            rose = !prev && enable_out;
            prev = enable_out;
        end while (!rose);
    endtask

    task automatic measure_window(input int idx);
        string name;
        int expected;
        int rises;
        int last_rise;
        int i;
        logic prev;
        logic cur;
        logic seen;
        name = row_names[idx];
        if (rows[idx].mode == mode_count && rows[idx].threshold < rows[idx].period) begin
            expected = window_cycles / int'(rows[idx].period);
        end else if (rows[idx].mode == mode_count) begin
            expected = 0;
        end else begin
            expected = int'(rows[idx].pulses);
        end
        rises = 0;
        last_rise = 0;
        seen = 1'b0;
        if (expected > 0) begin
            wait_rise(name, 2 * int'(rows[idx].period) + 16);
            seen = 1'b1;
        end
        prev = enable_out;
        for (i = 1; i <= window_cycles; i = i + 1) begin
            @(negedge clock);
            cur = enable_out;
            if (rows[idx].mode == mode_idle) check_bit({name, " level"}, 1'b0, cur);
            if (prev && cur) check_bit({name, " pulse width"}, 1'b0, cur);
            if (!prev && cur) begin
                rises = rises + 1;
                if (seen) begin
                    check_word({name, " spacing"}, bus_word_t'(rows[idx].spacing),
                               bus_word_t'(i - last_rise));
                end
                seen = 1'b1;
                last_rise = i;
            end
            prev = cur;
            drive_random_timebase();
        end
        check_word({name, " pulse count"}, bus_word_t'(expected), bus_word_t'(rises));
    endtask

    // The output must repeat the timebase bit driven one clock earlier
    task automatic follow_timebase(input int idx);
        logic driven;
        int i;
        drive_random_timebase();
        driven = ext_timebase;
        for (i = 0; i < pass_cycles; i = i + 1) begin
            @(negedge clock);
            check_bit({row_names[idx], " pass-through"}, driven, enable_out);
            drive_random_timebase();
            driven = ext_timebase;
        end
    endtask

    task automatic stop_generator(input int idx);
        int i;
        gen_enable_in = 1'b0;
        wb_write(reg_addr(reg_ctrl), 32'h0);
        repeat (3) @(negedge clock);
        for (i = 0; i < 16; i = i + 1) begin
            drive_random_timebase();
            @(negedge clock);
            check_bit({row_names[idx], " back to idle"}, 1'b0, enable_out);
        end
    endtask

    task automatic run_row(input int idx);
        wb_write(reg_addr(reg_period), bus_word_t'(rows[idx].period));
        wb_write(reg_addr(reg_threshold), bus_word_t'(rows[idx].threshold));
        gen_enable_in = rows[idx].gen_en;
        wb_write(reg_addr(reg_ctrl), {31'd0, rows[idx].run});
        repeat (4) @(negedge clock);
        if (rows[idx].mode == mode_pass) begin
            follow_timebase(idx);
        end else begin
            measure_window(idx);
        end
        stop_generator(idx);
    endtask

    initial begin
        int idx;
        seed = 13;
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        gen_enable_in = 1'b0;
        ext_timebase = 1'b0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        check_bit("reset wb_ack", 1'b0, wb_ack);
        check_bit("reset enable_out", 1'b0, enable_out);
        register_readback();
        for (idx = 0; idx < num_rows; idx = idx + 1) begin
            run_row(idx);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
